// File: peBlock.f
+incdir+dv
verilog/peDataPkg.sv
verilog/peFlowPkg.sv
verilog/actLink.sv
verilog/peColumn.sv
verilog/psumPingPong.sv
verilog/peBlock.sv
dv/peBlock_assertions.sv
dv/peBlockTb.sv

// File: dv/peBlockTests.svh
// PE block test sequences

task automatic testSingleBlock();
    startTest("single_block");
    for (int r = 0; r < PsumRows; r++) begin
        sendBeat(randomVec(), flagVecT'($random(seed)), r, 1'b1);
    end
    finishFrame();
    readFrame();
    endTest();
endtask

task automatic testMultiBlock();
    startTest("multi_block");
    // Consecutive blocks on one row go through the write bypass
    for (int r = 0; r < PsumRows; r++) begin
        for (int b = 0; b < 3; b++) begin
            sendBeat(randomVec(), flagVecT'($random(seed)), r, b == 0);
        end
    end
    // Restart a few rows, then add to them once more
    for (int r = 0; r < 4; r++) begin
        sendBeat(randomVec(), flagVecT'($random(seed)), r, 1'b1);
    end
    for (int r = 0; r < 4; r++) begin
        sendBeat(randomVec(), flagVecT'($random(seed)), r, 1'b0);
    end
    finishFrame();
    readFrame();
    endTest();
endtask

task automatic testFlagMask();
    flagVecT flags;
    startTest("flag_mask");
    for (int r = 0; r < PsumRows; r++) begin
        flags = (r < 4) ? flagVecT'(0) : (r < 8) ? '1 : flagVecT'($random(seed));
        sendBeat(randomVec(), flags, r, 1'b1);
    end
    // Fully masked blocks add nothing
    for (int r = 8; r < PsumRows; r++) begin
        sendBeat(randomVec(), flagVecT'(0), r, 1'b0);
    end
    finishFrame();
    readFrame();
    endTest();
endtask

task automatic testPingPong();
    startTest("ping_pong");
    for (int r = 0; r < PsumRows; r++) begin
        sendBeat(randomVec(), flagVecT'($random(seed)), r, 1'b1);
    end
    finishFrame();
    // Next frame fills one bank while the last one is read from the other
    for (int k = 0; k < 3; k++) begin
        fork
            begin
                for (int r = 0; r < PsumRows; r++) begin
                    sendBeat(randomVec(), flagVecT'($random(seed)), r, 1'b1);
                end
                idleCycles(1);
            end
            readFrame();
        join
        finishFrame();
    end
    readFrame();
    endTest();
endtask

task automatic testCredits();
    int pulses0;
    int sent0;
    startTest("credits");
    pulses0 = creditPulses;
    sent0   = sentBeats;
    for (int i = 0; i < 40; i++) begin
        sendBeat(randomVec(), flagVecT'($random(seed)), i % PsumRows, i < PsumRows);
        idleCycles($unsigned($random(seed)) % 4);
    end
    finishFrame();
    compareCount("credit pulses", sentBeats - sent0, creditPulses - pulses0);
    compareCredit("credits held", creditCountT'(CreditDepth), creditCnt);
    readFrame();
    endTest();
endtask

task automatic testReset();
    startTest("reset");
    @(posedge clk);
    #2;
    rst_n = 1'b0;
    repeat (4) begin
        @(negedge clk);
        checkCreditLow();
    end
    @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    checkCreditLow();
    clearModel();
    for (int r = 0; r < PsumRows; r++) begin
        poolExp[r] = '0;
    end
    // Both banks must read back empty
    readFrame();
    pulseFrameDone();
    readFrame();
    endTest();
endtask

// Run time bound
initial begin
    repeat (WatchdogCycles) @(posedge clk);
    $display("Timeout: tests did not finish within %0d cycles", WatchdogCycles);
    $display("Verification failed");
    $finish;
end

// File: dv/peBlockTb.sv
// PE block testbench
module peBlockTb
    import peDataPkg::*;
    import peFlowPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CreditDepth    = 2;
    localparam int PsumRows       = 16;
    localparam int PlannedBeats   = 200;
    localparam int WatchdogCycles = PlannedBeats * 10 + 2000;

    // ========================================================================
    // DUT signals and model state
    // ========================================================================
    logic                    clk;
    logic                    rst_n;
    logic                    actValid;
    actVecT                  actData;
    flagVecT                 actFlags;
    logic [RowAddrWidth-1:0] actRow;
    logic                    actFirstBlk;
    logic                    actCredit;
    logic [2:0]              wgtLoad;
    wgtVecT                  wgtData;
    logic                    frameDone;
    logic                    poolRdEn;
    logic [RowAddrWidth-1:0] poolAddr;
    psumT                    poolData;

    wgtVecT                  colWgt [3];
    actVecT                  qAct [$];
    flagVecT                 qFlags [$];
    logic [RowAddrWidth-1:0] qRow [$];
    logic                    qFirst [$];
    psumT                    poolExp [PsumRows];
    creditCountT             creditCnt;
    logic                    rdIssued;
    logic [RowAddrWidth-1:0] rdAddrD;
    int                      sentBeats;
    int                      creditPulses;
    int                      seed;
    string                   curTest;
    int                      errCount;
    int                      checkCount;
    int                      testCount;
    int                      errAtStart;
    int                      assertFails;

    peBlock #(.CreditDepth(CreditDepth), .PsumRows(PsumRows)) u_peBlock (
        .clk(clk), .rst_n(rst_n),
        .actValid(actValid), .actData(actData), .actFlags(actFlags), .actRow(actRow),
        .actFirstBlk(actFirstBlk), .actCredit(actCredit),
        .wgtLoad(wgtLoad), .wgtData(wgtData),
        .frameDone(frameDone), .poolRdEn(poolRdEn), .poolAddr(poolAddr), .poolData(poolData)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Sender credits, counted where actValid and actCredit are stable
    always @(negedge clk) begin
        if (!rst_n) begin
            creditCnt <= creditCountT'(CreditDepth);
        end else begin
            creditPulses <= creditPulses + int'(actCredit);
            sentBeats    <= sentBeats + int'(actValid);
            creditCnt    <= creditCnt + creditCountT'(actCredit) - creditCountT'(actValid);
        end
    end

    // Pool read compare, data is registered one cycle after the request
    always @(posedge clk) begin
        rdIssued <= poolRdEn;
        rdAddrD  <= poolAddr;
    end

    always @(negedge clk) begin
        if (rdIssued === 1'b1) begin
            comparePsum($sformatf("row %0d", rdAddrD), poolExp[rdAddrD], poolData);
        end
    end

    // ========================================================================
    // Reference model and checks
    // ========================================================================
    // Sum of flagged products over three columns, firstBlk restarts the row
    function automatic psumT expectPsum(input int row);
        psumT acc;
        psumT blk;
        acc = '0;
        for (int i = 0; i < qAct.size(); i++) begin
            if (qRow[i] == row) begin
                blk = '0;
                for (int c = 0; c < 3; c++) begin
                    for (int k = 0; k < BlockDepth; k++) begin
                        if (qFlags[i][k]) begin
                            blk = blk + qAct[i][k] * colWgt[c][k];
                        end
                    end
                end
                acc = qFirst[i] ? blk : acc + blk;
            end
        end
        return acc;
    endfunction

    task automatic comparePsum(input string what, input psumT expected, input psumT actual);
        checkCount++;
        if (actual !== expected) begin
            errCount++;
            $display("Mismatch in %s, %s: expected %0d, actual %0d",
                     curTest, what, expected, actual);
        end
    endtask

    task automatic compareCredit(input string what, input creditCountT expected,
                                 input creditCountT actual);
        checkCount++;
        if (actual !== expected) begin
            errCount++;
            $display("Mismatch in %s, %s: expected %0d, actual %0d",
                     curTest, what, expected, actual);
        end
    endtask

    task automatic compareCount(input string what, input int expected, input int actual);
        checkCount++;
        if (actual != expected) begin
            errCount++;
            $display("Mismatch in %s, %s: expected %0d, actual %0d",
                     curTest, what, expected, actual);
        end
    endtask

    task automatic checkCreditLow();
        checkCount++;
        if (actCredit !== 1'b0) begin
            errCount++;
            $display("Error in %s: actCredit is not low around reset", curTest);
        end
    endtask

    // ========================================================================
    // Stimulus helpers
    // ========================================================================
    function automatic actVecT randomVec();
        actVecT v;
        for (int k = 0; k < BlockDepth; k++) begin
            v[k] = dataT'($random(seed));
        end
        return v;
    endfunction

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
            actValid = 1'b0;
        end
    endtask

    // Holds the beat back until a credit is free
    task automatic sendBeat(input actVecT a, input flagVecT f, input int row,
                            input logic first);
        @(posedge clk);
        #2;
        while (creditCnt == '0) begin
            actValid = 1'b0;
            @(posedge clk);
            #2;
        end
        actValid    = 1'b1;
        actData     = a;
        actFlags    = f;
        actRow      = row[RowAddrWidth-1:0];
        actFirstBlk = first;
        qAct.push_back(a);
        qFlags.push_back(f);
        qRow.push_back(row[RowAddrWidth-1:0]);
        qFirst.push_back(first);
    endtask

    task automatic loadWeights();
        for (int c = 0; c < 3; c++) begin
            @(posedge clk);
            #2;
            wgtLoad   = 3'b001 << c;
            wgtData   = randomVec();
            colWgt[c] = wgtData;
        end
        @(posedge clk);
        #2;
        wgtLoad = '0;
    endtask

    task automatic clearModel();
        qAct.delete();
        qFlags.delete();
        qRow.delete();
        qFirst.delete();
    endtask

    task automatic pulseFrameDone();
        @(posedge clk);
        #2;
        frameDone = 1'b1;
        @(posedge clk);
        #2;
        frameDone = 1'b0;
    endtask

    // Drain all credits, let the pipeline settle, then swap banks
    task automatic finishFrame();
        idleCycles(1);
        while (creditCnt != creditCountT'(CreditDepth)) @(posedge clk);
        repeat (8) @(posedge clk);
        pulseFrameDone();
        for (int r = 0; r < PsumRows; r++) begin
            poolExp[r] = expectPsum(r);
        end
        clearModel();
    endtask

    task automatic readFrame();
        for (int r = 0; r < PsumRows; r++) begin
            @(posedge clk);
            #2;
            poolRdEn = 1'b1;
            poolAddr = RowAddrWidth'(r);
        end
        @(posedge clk);
        #2;
        poolRdEn = 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic startTest(input string name);
        curTest    = name;
        errAtStart = errCount;
        testCount++;
    endtask

    task automatic endTest();
        $display("Test %s finished with %0d errors", curTest, errCount - errAtStart);
    endtask

    `include "peBlockTests.svh"

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        seed         = 32'hecfe_f4c3;
        errCount     = 0;
        checkCount   = 0;
        testCount    = 0;
        sentBeats    = 0;
        creditPulses = 0;
        rst_n        = 1'b1;
        actValid     = 1'b0;
        actData      = '0;
        actFlags     = '0;
        actRow       = '0;
        actFirstBlk  = 1'b0;
        wgtLoad      = '0;
        wgtData      = '0;
        frameDone    = 1'b0;
        poolRdEn     = 1'b0;
        poolAddr     = '0;
        #2;
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        loadWeights();
        testSingleBlock();
        testMultiBlock();
        testFlagMask();
        testPingPong();
        testCredits();
        testReset();
        assertFails = u_peBlock.column0.columnChecks.failCount
                    + u_peBlock.column1.columnChecks.failCount
                    + u_peBlock.column2.columnChecks.failCount;
        if (assertFails != 0) begin
            errCount += assertFails;
            $display("Column checkers reported %0d assertion failures", assertFails);
        end
        $display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errCount);
        if (errCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: dv/peBlock_assertions.sv
// Column credit and reset checks
module creditChecks
    import peFlowPkg::*;
#(
    parameter int CreditDepth = 2
) (
    input logic        clk,
    input logic        rst_n,
    input logic        upValid,
    input logic        upCredit,
    input logic        downValid,
    input logic        pop,
    input creditCountT fillCount
);
    timeunit 1ns;
    timeprecision 100ps;

    // Read by the testbench at the end of the run
    int failCount = 0;

    // A sender holds one credit per free buffer entry
    validNeedsCredit: assert property (
        @(posedge clk) disable iff (!rst_n) upValid |-> fillCount < CreditDepth
    ) else begin
        failCount++;
        $error("Valid beat sent without a credit");
    end

    // A beat only arrives when a slot is free or draining
    noOverflow: assert property (
        @(posedge clk) disable iff (!rst_n) upValid |-> (fillCount < CreditDepth) || pop
    ) else begin
        failCount++;
        $error("Beat arrived at a full column buffer");
    end

    // Link stays quiet while reset is held
    quietInReset: assert property (
        @(posedge clk) !rst_n |-> !downValid && !upCredit
    ) else begin
        failCount++;
        $error("Valid or credit high during reset");
    end

endmodule

bind peColumn creditChecks #(.CreditDepth(CreditDepth)) columnChecks (
    .clk         (clk),
    .rst_n       (rst_n),
    .upValid     (upLink.valid),
    .upCredit    (upLink.credit),
    .downValid   (downLink.valid),
    .pop         (pop),
    .fillCount   (fillCount)
);

// File: verilog/peBlock.sv
// PE block top level
module peBlock
    import peDataPkg::*;
    import peFlowPkg::*;
#(
    parameter int CreditDepth = 2,
    parameter int PsumRows    = 16
) (
    input  logic                    clk,
    input  logic                    rst_n,

    // Activation stream
    input  logic                    actValid,
    input  actVecT                  actData,
    input  flagVecT                 actFlags,
    input  logic [RowAddrWidth-1:0] actRow,
    input  logic                    actFirstBlk,
    output logic                    actCredit,

    // Weight load, one strobe per column
    input  logic [2:0]              wgtLoad,
    input  wgtVecT                  wgtData,

    // Frame control and pooling side
    input  logic                    frameDone,
    input  logic                    poolRdEn,
    input  logic [RowAddrWidth-1:0] poolAddr,
    output psumT                    poolData
);

    // =========================================================================
    // Links
    // =========================================================================
    actLink link0 ();
    actLink link1 ();
    actLink link2 ();

    // Column 2 result toward the psum memory
    actLink linkOut ();

    // Column 0 starts the partial sum at zero
    assign link0.valid = actValid;
    assign link0.beat  = '{
        act:      actData,
        flags:    actFlags,
        row:      actRow,
        firstBlk: actFirstBlk,
        psum:     '0
    };
    assign actCredit = link0.credit;

    // Psum memory takes a beat every cycle, credit comes straight back
    assign linkOut.credit = linkOut.valid;

    // =========================================================================
    // Columns
    // =========================================================================
    peColumn #(.CreditDepth(CreditDepth)) column0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .wgtLoad  (wgtLoad[0]),
        .wgtData  (wgtData),
        .upLink   (link0),
        .downLink (link1)
    );

    peColumn #(.CreditDepth(CreditDepth)) column1 (
        .clk      (clk),
        .rst_n    (rst_n),
        .wgtLoad  (wgtLoad[1]),
        .wgtData  (wgtData),
        .upLink   (link1),
        .downLink (link2)
    );

    peColumn #(.CreditDepth(CreditDepth)) column2 (
        .clk      (clk),
        .rst_n    (rst_n),
        .wgtLoad  (wgtLoad[2]),
        .wgtData  (wgtData),
        .upLink   (link2),
        .downLink (linkOut)
    );

    // =========================================================================
    // Psum memory
    // =========================================================================
    psumPingPong #(.PsumRows(PsumRows)) u_pingPong (
        .clk        (clk),
        .rst_n      (rst_n),
        .inValid    (linkOut.valid),
        .inRow      (linkOut.beat.row),
        .inFirstBlk (linkOut.beat.firstBlk),
        .inPsum     (linkOut.beat.psum),
        .frameDone  (frameDone),
        .poolRdEn   (poolRdEn),
        .poolAddr   (poolAddr),
        .poolData   (poolData)
    );

endmodule

// File: verilog/psumPingPong.sv
// Ping-pong psum row accumulator
module psumPingPong
    import peDataPkg::*;
    import peFlowPkg::*;
#(
    parameter int PsumRows = 16
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    inValid,
    input  logic [RowAddrWidth-1:0] inRow,
    input  logic                    inFirstBlk,
    input  psumT                    inPsum,
    input  logic                    frameDone,
    input  logic                    poolRdEn,
    input  logic [RowAddrWidth-1:0] poolAddr,
    output psumT                    poolData
);

    // =========================================================================
    // Declarations
    // =========================================================================
    psumT                    bank [2][PsumRows];
    logic                    activeBank;
    logic                    inactiveBank;

    // Read stage
    logic                    s1Valid;
    logic [RowAddrWidth-1:0] s1Row;
    logic                    s1FirstBlk;
    psumT                    s1Psum;
    psumT                    s1Old;

    // Write stage
    psumT                    wrData;
    logic                    bypass;

    assign inactiveBank = ~activeBank;

    // First block of a row overwrites, later blocks accumulate
    assign wrData = s1FirstBlk ? s1Psum : s1Old + s1Psum;

    // Row being written this cycle is the one being read
    assign bypass = s1Valid && (s1Row == inRow);

    // =========================================================================
    // Bank select
    // =========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            activeBank <= 1'b0;
        end else if (frameDone) begin
            activeBank <= ~activeBank;
        end
    end

    // =========================================================================
    // Read stage
    // =========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1Valid <= 1'b0;
        end else begin
            s1Valid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            s1Row      <= inRow;
            s1FirstBlk <= inFirstBlk;
            s1Psum     <= inPsum;
            s1Old      <= bypass ? wrData : bank[activeBank][inRow];
        end
    end

    // =========================================================================
    // Write stage and banks
    // =========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int b = 0; b < 2; b++) begin
                for (int r = 0; r < PsumRows; r++) begin
                    bank[b][r] <= '0;
                end
            end
        end else if (s1Valid) begin
            bank[activeBank][s1Row] <= wrData;
        end
    end

    // =========================================================================
    // Pool read port
    // =========================================================================
    // Pooling only ever sees the finished frame
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            poolData <= '0;
        end else if (poolRdEn) begin
            poolData <= bank[inactiveBank][poolAddr];
        end
    end

endmodule

// File: verilog/peColumn.sv
// Processing column with credit buffer
module peColumn
    import peDataPkg::*;
    import peFlowPkg::*;
#(
    parameter int CreditDepth = 2
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wgtLoad,
    input  wgtVecT   wgtData,
    actLink.receiver upLink,
    actLink.sender   downLink
);

    localparam int PtrWidth = (CreditDepth > 1) ? $clog2(CreditDepth) : 1;

    // =========================================================================
    // Declarations
    // =========================================================================
    actBeatT             beatBuf [CreditDepth];
    logic [PtrWidth-1:0] wrPtr;
    logic [PtrWidth-1:0] rdPtr;
    creditCountT         fillCount;
    creditCountT         downCredits;
    wgtVecT              weights;
    logic                pop;
    actBeatT             headBeat;
    psumT                dotSum;
    actBeatT             resultBeat;

    function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
        if (ptr == PtrWidth'(CreditDepth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // =========================================================================
    // Input buffer
    // =========================================================================
    // Sender holds a credit for every free entry, so a valid beat always fits
    always_ff @(posedge clk) begin
        if (upLink.valid) begin
            beatBuf[wrPtr] <= upLink.beat;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            fillCount <= '0;
        end else begin
            if (upLink.valid) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({upLink.valid, pop})
                2'b10:   fillCount <= fillCount + 1'b1;
                2'b01:   fillCount <= fillCount - 1'b1;
                default: fillCount <= fillCount;
            endcase
        end
    end

    assign headBeat = beatBuf[rdPtr];

    // Drain needs a stored beat and room downstream
    assign pop = (fillCount != '0) && (downCredits != '0);

    // Credit goes back upstream in the pop cycle
    assign upLink.credit = pop;

    // =========================================================================
    // Downstream credits
    // =========================================================================
    // Spent at pop, one cycle ahead of the registered valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            downCredits <= creditCountT'(CreditDepth);
        end else begin
            case ({pop, downLink.credit})
                2'b10:   downCredits <= downCredits - 1'b1;
                2'b01:   downCredits <= downCredits + 1'b1;
                default: downCredits <= downCredits;
            endcase
        end
    end

    // =========================================================================
    // Weights and masked dot product
    // =========================================================================
    always_ff @(posedge clk) begin
        if (wgtLoad) begin
            weights <= wgtData;
        end
    end

    always_comb begin
        prodT prod;
        dotSum = '0;
        for (int i = 0; i < BlockDepth; i++) begin
            prod = $signed(headBeat.act[i]) * $signed(weights[i]);
            // Zero activations are flagged off and skipped
            if (headBeat.flags[i]) begin
                dotSum = dotSum + prod;
            end
        end
    end

    // Everything but the psum passes through untouched
    always_comb begin
        resultBeat      = headBeat;
        resultBeat.psum = headBeat.psum + dotSum;
    end

    // =========================================================================
    // Output register
    // =========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            downLink.valid <= 1'b0;
        end else begin
            downLink.valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            downLink.beat <= resultBeat;
        end
    end

endmodule

// File: verilog/actLink.sv
// Credit-based activation link
interface actLink
    import peFlowPkg::*;
();

    // Beat qualifier from sender
    logic    valid;

    // Block payload
    actBeatT beat;

    // One-cycle pulse per drained buffer entry
    logic    credit;

    // Sender side, spends one credit per valid beat
    modport sender (
        output valid,
        output beat,
        input  credit
    );

    // Receiver side, must absorb every valid beat
    modport receiver (
        input  valid,
        input  beat,
        output credit
    );

endinterface

// File: verilog/peFlowPkg.sv
// Activation beat and credit types
package peFlowPkg;
    import peDataPkg::*;

    // =========================================================================
    // Row addressing and credits
    // =========================================================================
    localparam int RowAddrWidth = 4;

    // Up to 15 outstanding credits
    typedef logic [3:0] creditCountT;

    // =========================================================================
    // Activation beat
    // =========================================================================
    // Psum rides along with the block through the columns
    typedef struct packed {
        actVecT                  act;
        flagVecT                 flags;
        logic [RowAddrWidth-1:0] row;
        logic                    firstBlk;
        psumT                    psum;
    } actBeatT;

endpackage

// File: verilog/peDataPkg.sv
// PE arithmetic widths and vector types
package peDataPkg;

    // =========================================================================
    // Widths
    // =========================================================================
    localparam int DataWidth  = 8;
    localparam int BlockDepth = 4;

    // Room for BlockDepth products plus three column adds
    localparam int PsumWidth  = 2 * DataWidth + 2 + 2;

    // =========================================================================
    // Types
    // =========================================================================
    // One signed activation or weight
    typedef logic signed [DataWidth-1:0] dataT;

    // Full-width product of one activation and one weight
    typedef logic signed [2*DataWidth-1:0] prodT;

    // One block of activations
    typedef dataT [BlockDepth-1:0] actVecT;

    // Weight vector held by a column
    typedef dataT [BlockDepth-1:0] wgtVecT;

    // Sparsity flags, one per activation
    typedef logic [BlockDepth-1:0] flagVecT;

    // Partial sum
    typedef logic signed [PsumWidth-1:0] psumT;

endpackage
